/* sources.f */
source/qspim_wb_pkg.sv
source/qspim_cmd_pkg.sv
source/qspim_cmd_if.sv
source/qspim_cmd_gen.sv
source/qspim_cmd_fifo.sv
source/qspim_rsp_ctrl.sv
source/qspim_if.sv
verification/tb_clk_gen.sv
verification/qspim_if_tb.sv

/* Bender.yml */
package:
  name: qspim_if

sources:
  - source/qspim_wb_pkg.sv
  - source/qspim_cmd_pkg.sv
  - source/qspim_cmd_if.sv
  - source/qspim_cmd_gen.sv
  - source/qspim_cmd_fifo.sv
  - source/qspim_rsp_ctrl.sv
  - source/qspim_if.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/qspim_if_tb.sv

/* verification/qspim_if_tb.sv */
// Testbench for the Wishbone to quad-SPI read front end
// Random flash bursts and register accesses from a fixed seed. Models the
// SPI controller, its response FIFO and the register block around the DUT

module qspim_if_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD     = 100;
  localparam int NUM_TXN        = 40;
  localparam int MAX_TXN_CYCLES = 200;  // 16 beats with gaps, plus pop delays
  localparam int WATCHDOG_NS    = (NUM_TXN + 2) * MAX_TXN_CYCLES * CLK_PERIOD;

  logic                    mclk;
  logic                    rst_n;
  logic                    wbd_stb_i;
  logic [31:0]             wbd_adr_i;
  logic                    wbd_we_i;
  logic [31:0]             wbd_dat_i;
  logic [3:0]              wbd_sel_i;
  logic [9:0]              wbd_bl_i;
  logic [31:0]             wbd_dat_o;
  logic                    wbd_ack_o;
  logic                    wbd_lack_o;
  logic [3:0][7:0]         cfg_cs_addr_i;
  logic [3:0][7:0]         cfg_cs_mask_i;
  qspim_cmd_pkg::rd_cfg_t  cfg_g0_i;
  qspim_cmd_pkg::rd_cfg_t  cfg_g1_i;
  logic                    spi_init_done_i;
  logic                    spim_reg_req_o;
  logic [3:0]              spim_reg_addr_o;
  logic                    spim_reg_we_o;
  logic [3:0]              spim_reg_be_o;
  logic [31:0]             spim_reg_wdata_o;
  logic                    spim_reg_ack_i;
  logic [31:0]             spim_reg_rdata_i;
  logic                    cmd_fifo_rd_i;
  logic [49:0]             cmd_fifo_rdata_o;
  logic                    cmd_fifo_empty_o;
  logic                    res_fifo_empty_i;
  logic                    res_fifo_rd_o;
  logic [31:0]             res_fifo_rdata_i;

  logic [49:0] exp_cmd_q[$];  // Header then address word of each read
  int          bl_q[$];       // Burst lengths for the controller model
  logic [31:0] rsp_src_q[$];  // Words the controller still has to deliver
  logic [31:0] rsp_q[$];      // Response FIFO contents
  logic [31:0] exp_dat_q[$];  // Burst data in order
  logic [31:0] exp_reg_q[$];  // Register read data

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(3)) i_clk_gen (
    .clk_o   (mclk),
    .rst_n_o (rst_n)
  );

  qspim_if #(.CMD_FIFO_DEPTH(4)) i_dut (.*);

  //------------------------------------------------------------
  // Checking helpers and command word model
  //------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic logic [49:0] exp_header(
    input logic [31:0] adr, input logic [9:0] bl,
    input logic [3:0][7:0] csa, input logic [3:0][7:0] msk,
    input qspim_cmd_pkg::rd_cfg_t g0, input qspim_cmd_pkg::rd_cfg_t g1);
    logic [3:0]             cs;
    logic [11:0]            dcnt;
    qspim_cmd_pkg::rd_cfg_t g;
    for (int n = 0; n < 4; n++) begin
      cs[n] = ((adr[27:20] & msk[n]) == csa[n]);  // Masked compare
    end
    g    = (cs == 4'b0100 || cs == 4'b1000) ? g1 : g0;  // Lone CS2/CS3 only
    dcnt = bl * 4;  // Bytes
    return {2'b10, dcnt, g.dummy_cnt, g.addr_cnt, g.switch, g.fmode, g.imode,
            g.seq, cs, g.mode, g.cmd};
  endfunction

  //------------------------------------------------------------
  // Bus master
  //------------------------------------------------------------
  task automatic release_bus();
    @(posedge mclk);
    wbd_stb_i <= 1'b0;  // Strobe drops after lack
    @(negedge mclk);
    check_value("wbd_ack_o", wbd_ack_o, 1'b0);  // No stray beat
  endtask

  task automatic mem_read();
    logic [31:0]            adr;
    logic [9:0]             bl;
    logic [7:0]             field;
    logic [3:0][7:0]        csa;
    logic [3:0][7:0]        msk;
    qspim_cmd_pkg::rd_cfg_t g0;
    qspim_cmd_pkg::rd_cfg_t g1;
    int                     k;
    int                     beats;
    logic                   done;
    for (int n = 0; n < 4; n++) begin
      msk[n] = 8'($urandom);
      csa[n] = 8'($urandom) & msk[n];  // Matchable pair
    end
    g0    = $urandom;
    g1    = $urandom;
    field = 8'($urandom);
    k     = $urandom_range(3, 0);
    if ($urandom_range(1, 0) == 1) begin
      field = (csa[k] & msk[k]) | (field & ~msk[k]);  // Force a hit on CS k
    end
    adr        = $urandom;
    adr[28]    = 1'b0;  // Flash space
    adr[27:20] = field;
    bl         = 10'($urandom_range(16, 1));
    exp_cmd_q.push_back(exp_header(adr, bl, csa, msk, g0, g1));
    exp_cmd_q.push_back({2'b01, 16'h0, adr[31:2], 2'b00});
    bl_q.push_back(bl);
    @(posedge mclk);
    cfg_cs_addr_i <= csa;
    cfg_cs_mask_i <= msk;
    cfg_g0_i      <= g0;
    cfg_g1_i      <= g1;
    wbd_stb_i     <= 1'b1;
    wbd_we_i      <= 1'b0;
    wbd_adr_i     <= adr;
    wbd_sel_i     <= 4'hf;
    wbd_bl_i      <= bl;
    beats = 0;
    done  = 1'b0;
    while (!done) begin
      @(negedge mclk);
      if (wbd_ack_o) begin
        beats++;
        if (exp_dat_q.size() == 0) begin
          report_error("Burst ack arrived before any response word was delivered");
        end else begin
          check_value("wbd_dat_o", wbd_dat_o, exp_dat_q.pop_front());
          check_value("wbd_lack_o", wbd_lack_o, beats == bl);  // Last beat only
          done = wbd_lack_o;
        end
      end
    end
    release_bus();
  endtask

  task automatic reg_access();
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    adr     = $urandom;
    adr[28] = 1'b1;  // Register space
    dat     = $urandom;
    sel     = 4'($urandom);
    we      = 1'($urandom);
    @(posedge mclk);
    wbd_stb_i <= 1'b1;
    wbd_we_i  <= we;
    wbd_adr_i <= adr;
    wbd_dat_i <= dat;
    wbd_sel_i <= sel;
    @(negedge mclk);
    check_value("spim_reg_req_o", spim_reg_req_o, 1'b1);
    check_value("spim_reg_addr_o", spim_reg_addr_o, adr[5:2]);
    check_value("spim_reg_we_o", spim_reg_we_o, we);
    check_value("spim_reg_be_o", spim_reg_be_o, sel);
    check_value("spim_reg_wdata_o", spim_reg_wdata_o, dat);
    do begin
      @(negedge mclk);
    end while (!wbd_ack_o);
    check_value("wbd_lack_o", wbd_lack_o, 1'b1);  // Single beat
    if (exp_reg_q.size() == 0) begin
      report_error("Register ack arrived without a register block response");
    end else begin
      check_value("wbd_dat_o", wbd_dat_o, exp_reg_q.pop_front());
    end
    release_bus();
  endtask

  initial begin
    void'($urandom(32'hebfe9019));
    wbd_stb_i       = 1'b0;
    wbd_adr_i       = '0;
    wbd_we_i        = 1'b0;
    wbd_dat_i       = '0;
    wbd_sel_i       = '0;
    wbd_bl_i        = '0;
    cfg_cs_addr_i   = '0;
    cfg_cs_mask_i   = '0;
    cfg_g0_i        = '0;
    cfg_g1_i        = '0;
    spi_init_done_i = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge mclk);
    check_value("wbd_ack_o", wbd_ack_o, 1'b0);
    check_value("wbd_lack_o", wbd_lack_o, 1'b0);
    check_value("res_fifo_rd_o", res_fifo_rd_o, 1'b0);
    check_value("spim_reg_req_o", spim_reg_req_o, 1'b0);
    check_value("cmd_fifo_empty_o", cmd_fifo_empty_o, 1'b1);
    // Both kinds of request held off until init is done
    @(posedge mclk);
    wbd_stb_i <= 1'b1;
    wbd_adr_i <= 32'h0012_3400;
    wbd_bl_i  <= 10'd4;
    repeat (6) begin
      @(negedge mclk);
      check_value("cmd_fifo_empty_o", cmd_fifo_empty_o, 1'b1);
    end
    @(posedge mclk);
    wbd_adr_i <= 32'h1000_0008;
    repeat (6) begin
      @(negedge mclk);
      check_value("spim_reg_req_o", spim_reg_req_o, 1'b0);
    end
    @(posedge mclk);
    wbd_stb_i       <= 1'b0;
    spi_init_done_i <= 1'b1;
    for (int t = 0; t < NUM_TXN; t++) begin
      repeat ($urandom_range(2, 0)) @(posedge mclk);
      if ($urandom_range(2, 0) == 0) begin
        reg_access();
      end else begin
        mem_read();
      end
    end
    repeat (4) @(negedge mclk);
    check_value("cmd_fifo_empty_o", cmd_fifo_empty_o, 1'b1);
    if (exp_cmd_q.size() != 0 || exp_dat_q.size() != 0) begin
      report_error("Command words or response data were left unconsumed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  //------------------------------------------------------------
  // Surrounding block models
  //------------------------------------------------------------
  // SPI controller pops and checks each command word after a random delay
  initial begin : spi_ctrl_model
    logic [31:0] word;
    int          word_idx;
    int          bl;
    cmd_fifo_rd_i = 1'b0;
    word_idx      = 0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge mclk);
      if (!cmd_fifo_empty_o) begin
        repeat ($urandom_range(4, 0)) @(negedge mclk);
        if (exp_cmd_q.size() == 0) begin
          report_error("Command FIFO holds a word that no read produced");
        end else begin
          check_value("cmd_fifo_rdata_o", cmd_fifo_rdata_o, exp_cmd_q.pop_front());
          if (word_idx == 1) begin  // Address word closes the command
            bl = bl_q.pop_front();
            repeat (bl) begin
              word = $urandom;
              rsp_src_q.push_back(word);
              exp_dat_q.push_back(word);
            end
          end
          word_idx = 1 - word_idx;
          @(posedge mclk);
          cmd_fifo_rd_i <= 1'b1;
          @(posedge mclk);
          cmd_fifo_rd_i <= 1'b0;
        end
      end
    end
  end

  // Response FIFO with words trickling in after random gaps
  initial begin : rsp_fifo_model
    logic pop_seen;
    int   gap;
    res_fifo_empty_i = 1'b1;
    res_fifo_rdata_i = '0;
    pop_seen         = 1'b0;
    gap              = 0;
    forever begin
      @(posedge mclk);
      if (pop_seen) void'(rsp_q.pop_front());
      if (gap > 0) begin
        gap--;
      end else if (rsp_src_q.size() > 0) begin
        rsp_q.push_back(rsp_src_q.pop_front());
        gap = $urandom_range(3, 0);
      end
      res_fifo_empty_i <= (rsp_q.size() == 0);
      res_fifo_rdata_i <= (rsp_q.size() > 0) ? rsp_q[0] : '0;  // Head word
      @(negedge mclk);
      pop_seen = (res_fifo_rd_o === 1'b1);
    end
  end

  // Register block acks each request once
  initial begin : reg_block_model
    logic [31:0] rdata;
    spim_reg_ack_i   = 1'b0;
    spim_reg_rdata_i = '0;
    forever begin
      @(negedge mclk);
      if (spim_reg_req_o === 1'b1) begin
        repeat ($urandom_range(3, 0)) @(negedge mclk);
        rdata = $urandom;
        exp_reg_q.push_back(rdata);
        @(posedge mclk);
        spim_reg_ack_i   <= 1'b1;
        spim_reg_rdata_i <= rdata;
        @(posedge mclk);
        spim_reg_ack_i   <= 1'b0;  // Lack then masks the held strobe
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $fatal(1);
  end

endmodule

/* verification/tb_clk_gen.sv */
// Clock and reset for the front end testbench
// Free-running clock, synchronous active-low reset released on a rising edge

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);  // Reset seen on each of these edges
    rst_n_o <= 1'b1;
  end

endmodule

/* source/qspim_if.sv */
// Wishbone slave front end for a quad-SPI flash controller
// Flash reads become header/address words in the internal command
// FIFO, popped by the SPI controller; data comes back through its
// response FIFO. Register accesses go straight to the register block

module qspim_if #(
  parameter int CMD_FIFO_DEPTH = 4
) (
  input  logic                                  mclk,
  input  logic                                  rst_n,

  // Wishbone slave
  input  logic                                  wbd_stb_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]     wbd_adr_i,
  input  logic                                  wbd_we_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]     wbd_dat_i,
  input  logic [qspim_wb_pkg::WB_SEL_W-1:0]     wbd_sel_i,
  input  logic [qspim_wb_pkg::BL_W-1:0]         wbd_bl_i,
  output logic [qspim_wb_pkg::WB_WIDTH-1:0]     wbd_dat_o,
  output logic                                  wbd_ack_o,
  output logic                                  wbd_lack_o,

  // Configuration
  input  logic [qspim_cmd_pkg::NUM_CS-1:0][qspim_cmd_pkg::CS_ADDR_W-1:0] cfg_cs_addr_i,
  input  logic [qspim_cmd_pkg::NUM_CS-1:0][qspim_cmd_pkg::CS_ADDR_W-1:0] cfg_cs_mask_i,
  input  qspim_cmd_pkg::rd_cfg_t                cfg_g0_i,  // CS0/CS1
  input  qspim_cmd_pkg::rd_cfg_t                cfg_g1_i,  // CS2/CS3

  input  logic                                  spi_init_done_i,

  // Register block
  output logic                                  spim_reg_req_o,
  output logic [qspim_wb_pkg::REG_ADDR_W-1:0]   spim_reg_addr_o,
  output logic                                  spim_reg_we_o,
  output logic [qspim_wb_pkg::WB_SEL_W-1:0]     spim_reg_be_o,
  output logic [qspim_wb_pkg::WB_WIDTH-1:0]     spim_reg_wdata_o,
  input  logic                                  spim_reg_ack_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]     spim_reg_rdata_i,

  // Command FIFO read side, SPI controller
  input  logic                                  cmd_fifo_rd_i,
  output logic [qspim_cmd_pkg::CMD_W-1:0]       cmd_fifo_rdata_o,
  output logic                                  cmd_fifo_empty_o,

  // Response FIFO, SPI controller
  input  logic                                  res_fifo_empty_i,
  output logic                                  res_fifo_rd_o,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]     res_fifo_rdata_i
);

  logic                           rd_start;
  logic [qspim_wb_pkg::BL_W-1:0]  rd_bl;
  logic                           rd_done;

  qspim_cmd_if u_cmd_bus ();

  qspim_cmd_gen u_cmd_gen (
    .mclk             (mclk),
    .rst_n            (rst_n),
    .wbd_stb_i        (wbd_stb_i),
    .wbd_we_i         (wbd_we_i),
    .wbd_adr_i        (wbd_adr_i),
    .wbd_dat_i        (wbd_dat_i),
    .wbd_sel_i        (wbd_sel_i),
    .wbd_bl_i         (wbd_bl_i),
    .spi_init_done_i  (spi_init_done_i),
    .wbd_lack_i       (wbd_lack_o),  // Masks the strobe still held
    .rd_done_i        (rd_done),
    .cfg_cs_addr_i    (cfg_cs_addr_i),
    .cfg_cs_mask_i    (cfg_cs_mask_i),
    .cfg_g0_i         (cfg_g0_i),
    .cfg_g1_i         (cfg_g1_i),
    .spim_reg_req_o   (spim_reg_req_o),
    .spim_reg_addr_o  (spim_reg_addr_o),
    .spim_reg_we_o    (spim_reg_we_o),
    .spim_reg_be_o    (spim_reg_be_o),
    .spim_reg_wdata_o (spim_reg_wdata_o),
    .rd_start_o       (rd_start),
    .rd_bl_o          (rd_bl),
    .cmd              (u_cmd_bus.producer)
  );

  qspim_cmd_fifo #(
    .CMD_FIFO_DEPTH (CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .mclk    (mclk),
    .rst_n   (rst_n),
    .rd_i    (cmd_fifo_rd_i),
    .rdata_o (cmd_fifo_rdata_o),
    .empty_o (cmd_fifo_empty_o),
    .cmd     (u_cmd_bus.fifo)
  );

  qspim_rsp_ctrl u_rsp_ctrl (
    .mclk             (mclk),
    .rst_n            (rst_n),
    .rd_start_i       (rd_start),
    .rd_bl_i          (rd_bl),
    .res_fifo_empty_i (res_fifo_empty_i),
    .res_fifo_rdata_i (res_fifo_rdata_i),
    .res_fifo_rd_o    (res_fifo_rd_o),
    .spim_reg_ack_i   (spim_reg_ack_i),
    .spim_reg_rdata_i (spim_reg_rdata_i),
    .rd_done_o        (rd_done),
    .wbd_ack_o        (wbd_ack_o),
    .wbd_lack_o       (wbd_lack_o),
    .wbd_dat_o        (wbd_dat_o)
  );

endmodule

/* source/qspim_rsp_ctrl.sv */
// Response side of the front end
// Drains the response FIFO for a flash burst and answers the bus
// with ack, last ack and data all registered

module qspim_rsp_ctrl (
  input  logic                               mclk,
  input  logic                               rst_n,

  // From the command generator
  input  logic                               rd_start_i,  // Burst begins
  input  logic [qspim_wb_pkg::BL_W-1:0]      rd_bl_i,     // Beats in the burst

  // Response FIFO
  input  logic                               res_fifo_empty_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]  res_fifo_rdata_i,
  output logic                               res_fifo_rd_o,

  // Register block
  input  logic                               spim_reg_ack_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]  spim_reg_rdata_i,

  output logic                               rd_done_o,   // Final beat popped

  // Wishbone response
  output logic                               wbd_ack_o,
  output logic                               wbd_lack_o,
  output logic [qspim_wb_pkg::WB_WIDTH-1:0]  wbd_dat_o
);

  localparam logic [qspim_wb_pkg::BL_W-1:0] ONE_BEAT = 1;

  logic                           active;    // Burst in progress
  logic [qspim_wb_pkg::BL_W-1:0]  beat_cnt;  // Beats still owed
  logic                           last_beat;

  //------------------------------------------------------------
  // Burst tracking
  //------------------------------------------------------------
  assign res_fifo_rd_o = active && !res_fifo_empty_i;  // Empty FIFO stalls the beat
  assign last_beat     = (beat_cnt == ONE_BEAT);
  assign rd_done_o     = res_fifo_rd_o && last_beat;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      active   <= 1'b0;
      beat_cnt <= '0;
    end else if (rd_start_i) begin
      active   <= 1'b1;
      beat_cnt <= rd_bl_i;
    end else if (res_fifo_rd_o) begin
      beat_cnt <= beat_cnt - 1'b1;
      if (last_beat) active <= 1'b0;
    end
  end

  //------------------------------------------------------------
  // Bus response
  //------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wbd_ack_o  <= 1'b0;
      wbd_lack_o <= 1'b0;
      wbd_dat_o  <= '0;
    end else begin
      wbd_ack_o  <= res_fifo_rd_o || spim_reg_ack_i;
      wbd_lack_o <= rd_done_o || spim_reg_ack_i;  // Register access is one beat
      if (res_fifo_rd_o) begin
        wbd_dat_o <= res_fifo_rdata_i;
      end else if (spim_reg_ack_i) begin
        wbd_dat_o <= spim_reg_rdata_i;
      end else begin
        wbd_dat_o <= '0;
      end
    end
  end

  // Generator waits for rd_done before it can start another burst
  a_start_idle: assert property (@(posedge mclk) disable iff (!rst_n)
    rd_start_i |-> !active);

endmodule

/* source/qspim_cmd_fifo.sv */
// Command FIFO between the generator and the SPI controller
// Circular buffer, head word always visible on rdata_o

module qspim_cmd_fifo #(
  parameter int CMD_FIFO_DEPTH = 4
) (
  input  logic                              mclk,
  input  logic                              rst_n,
  input  logic                              rd_i,     // Pop from the SPI controller
  output logic [qspim_cmd_pkg::CMD_W-1:0]   rdata_o,  // Head word
  output logic                              empty_o,
  qspim_cmd_if.fifo                         cmd
);

  localparam int PTR_W = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(CMD_FIFO_DEPTH + 1);

  logic [qspim_cmd_pkg::CMD_W-1:0]  mem [CMD_FIFO_DEPTH];
  logic [PTR_W-1:0]                 wr_ptr;
  logic [PTR_W-1:0]                 rd_ptr;
  logic [CNT_W-1:0]                 count;   // Occupancy
  logic                             do_wr;
  logic                             do_rd;

  // Wrap at the depth, works for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(CMD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_wr = cmd.wr && !cmd.full;
  assign do_rd = rd_i && !cmd.empty;

  assign cmd.full  = (count == CNT_W'(CMD_FIFO_DEPTH));
  assign cmd.empty = (count == '0);
  assign empty_o   = cmd.empty;
  assign rdata_o   = mem[rd_ptr];

  //------------------------------------------------------------
  // Pointers and count
  //------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_next(wr_ptr);
      if (do_rd) rd_ptr <= ptr_next(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge mclk) begin
    if (do_wr) mem[wr_ptr] <= cmd.wdata;
  end

  a_no_wr_full: assert property (@(posedge mclk) disable iff (!rst_n)
    cmd.wr |-> !cmd.full);

  // SPI controller pops only what it sees
  a_no_rd_empty: assert property (@(posedge mclk) disable iff (!rst_n)
    rd_i |-> !cmd.empty);

endmodule

/* source/qspim_cmd_gen.sv */
// Request side of the front end
// Splits flash reads from register accesses, picks the chip select and
// config group, and pushes the header and address words for each read

module qspim_cmd_gen (
  input  logic                                  mclk,
  input  logic                                  rst_n,

  // Wishbone request
  input  logic                                  wbd_stb_i,
  input  logic                                  wbd_we_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]     wbd_adr_i,
  input  logic [qspim_wb_pkg::WB_WIDTH-1:0]     wbd_dat_i,
  input  logic [qspim_wb_pkg::WB_SEL_W-1:0]     wbd_sel_i,
  input  logic [qspim_wb_pkg::BL_W-1:0]         wbd_bl_i,

  input  logic                                  spi_init_done_i,
  input  logic                                  wbd_lack_i,  // Last ack in flight
  input  logic                                  rd_done_i,   // Final beat popped

  // Chip-select map and read config groups
  input  logic [qspim_cmd_pkg::NUM_CS-1:0][qspim_cmd_pkg::CS_ADDR_W-1:0] cfg_cs_addr_i,
  input  logic [qspim_cmd_pkg::NUM_CS-1:0][qspim_cmd_pkg::CS_ADDR_W-1:0] cfg_cs_mask_i,
  input  qspim_cmd_pkg::rd_cfg_t                cfg_g0_i,
  input  qspim_cmd_pkg::rd_cfg_t                cfg_g1_i,

  // Register block
  output logic                                  spim_reg_req_o,
  output logic [qspim_wb_pkg::REG_ADDR_W-1:0]   spim_reg_addr_o,
  output logic                                  spim_reg_we_o,
  output logic [qspim_wb_pkg::WB_SEL_W-1:0]     spim_reg_be_o,
  output logic [qspim_wb_pkg::WB_WIDTH-1:0]     spim_reg_wdata_o,

  // Response controller
  output logic                                  rd_start_o,
  output logic [qspim_wb_pkg::BL_W-1:0]         rd_bl_o,

  qspim_cmd_if.producer                         cmd
);

  qspim_cmd_pkg::cmd_state_e               state;
  qspim_cmd_pkg::cmd_state_e               next_state;
  qspim_cmd_pkg::rd_cfg_t                  cfg_sel;
  logic [qspim_cmd_pkg::NUM_CS-1:0]        cs_vec;
  logic [qspim_cmd_pkg::DCNT_W-1:0]        data_cnt;
  logic [qspim_cmd_pkg::CMD_W-1:0]         hdr_word;
  logic [qspim_cmd_pkg::CMD_W-1:0]         adr_word;
  logic [qspim_wb_pkg::WB_WIDTH-1:0]       addr_q;
  logic                                    req_ok;
  logic                                    mem_req;
  logic                                    accept;

  //------------------------------------------------------------
  // Address decode
  //------------------------------------------------------------
  // No request of either kind before init or while the last ack is out
  assign req_ok  = spi_init_done_i && wbd_stb_i && !wbd_lack_i;
  assign mem_req = req_ok && !wbd_adr_i[qspim_wb_pkg::REG_SEL_BIT];

  assign spim_reg_req_o   = req_ok && wbd_adr_i[qspim_wb_pkg::REG_SEL_BIT];
  assign spim_reg_addr_o  = wbd_adr_i[qspim_wb_pkg::REG_ADDR_W+1:2];  // Word index
  assign spim_reg_we_o    = wbd_we_i;
  assign spim_reg_be_o    = wbd_sel_i;
  assign spim_reg_wdata_o = wbd_dat_i;

  // Masked compare of the chip-select field
  for (genvar n = 0; n < qspim_cmd_pkg::NUM_CS; n++) begin : g_cs
    assign cs_vec[n] = ((wbd_adr_i[qspim_wb_pkg::CS_MSB:qspim_wb_pkg::CS_LSB]
                        & cfg_cs_mask_i[n]) == cfg_cs_addr_i[n]);
  end

  // CS2/CS3 alone take group 1, anything else group 0
  always_comb begin
    case (cs_vec)
      4'b0100, 4'b1000: cfg_sel = cfg_g1_i;
      default:          cfg_sel = cfg_g0_i;
    endcase
  end

  //------------------------------------------------------------
  // Command words
  //------------------------------------------------------------
  assign data_cnt = {wbd_bl_i, 2'b00};  // Words to bytes

  always_comb begin
    hdr_word = '0;
    hdr_word[qspim_cmd_pkg::SOC_BIT] = 1'b1;
    hdr_word[qspim_cmd_pkg::EOC_BIT-1:0] = {data_cnt, cfg_sel.dummy_cnt,
                                            cfg_sel.addr_cnt, cfg_sel.switch,
                                            cfg_sel.fmode, cfg_sel.imode,
                                            cfg_sel.seq, cs_vec,
                                            cfg_sel.mode, cfg_sel.cmd};
  end

  always_comb begin
    adr_word = '0;
    adr_word[qspim_cmd_pkg::EOC_BIT] = 1'b1;  // Last word of the command
    adr_word[qspim_cmd_pkg::EOC_BIT-1:0] = {16'h0, addr_q[qspim_wb_pkg::WB_WIDTH-1:2], 2'b00};
  end

  //------------------------------------------------------------
  // Command FSM
  //------------------------------------------------------------
  // Only start once the previous command has left the FIFO
  assign accept = (state == qspim_cmd_pkg::IDLE) && mem_req && cmd.empty;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      state <= qspim_cmd_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Address and burst length held for the whole read
  always_ff @(posedge mclk) begin
    if (accept) begin
      addr_q  <= wbd_adr_i;
      rd_bl_o <= wbd_bl_i;
    end
  end

  always_comb begin
    next_state = state;
    cmd.wr     = 1'b0;
    cmd.wdata  = '0;
    rd_start_o = 1'b0;
    case (state)
      qspim_cmd_pkg::IDLE: begin
        if (accept) begin
          cmd.wr     = 1'b1;
          cmd.wdata  = hdr_word;
          next_state = qspim_cmd_pkg::ADR_PHASE;
        end
      end
      qspim_cmd_pkg::ADR_PHASE: begin
        cmd.wr     = 1'b1;
        cmd.wdata  = adr_word;
        next_state = qspim_cmd_pkg::CMD_WAIT;
      end
      qspim_cmd_pkg::CMD_WAIT: begin
        // Controller has taken both words, response data is fresh
        if (cmd.empty) begin
          rd_start_o = 1'b1;
          next_state = qspim_cmd_pkg::READ_DATA;
        end
      end
      qspim_cmd_pkg::READ_DATA: begin
        if (rd_done_i) next_state = qspim_cmd_pkg::IDLE;
      end
      default: next_state = qspim_cmd_pkg::IDLE;
    endcase
  end

  // Header and address go back to back, FIFO must never be full here
  a_no_wr_full: assert property (@(posedge mclk) disable iff (!rst_n)
    cmd.wr |-> !cmd.full);

endmodule

/* source/qspim_cmd_if.sv */
// Write side of the command FIFO
// Generator pushes one word per wr pulse, never while full is high

interface qspim_cmd_if;

  logic                             wr;     // One-cycle write strobe
  logic [qspim_cmd_pkg::CMD_W-1:0]  wdata;  // Command word
  logic                             full;   // No room left
  logic                             empty;  // All words popped

  modport producer (
    output wr,
    output wdata,
    input  full,
    input  empty
  );

  modport fifo (
    input  wr,
    input  wdata,
    output full,
    output empty
  );

endinterface

/* source/qspim_cmd_pkg.sv */
// SPI command side definitions: command word layout, read
// configuration group, mode and FSM state encodings

package qspim_cmd_pkg;

  localparam int NUM_CS    = 4;   // Chip selects
  localparam int CS_ADDR_W = 8;   // Address/mask width per chip select
  localparam int CMD_W     = 50;  // Command FIFO word
  localparam int DCNT_W    = 12;  // Byte count in the header word

  // Flags at the top of every command word
  localparam int SOC_BIT = 49;  // Start of command
  localparam int EOC_BIT = 48;  // End of command

  // Lane mode on the SPI side
  typedef enum logic [1:0] {
    SPI_SINGLE = 2'b00,
    SPI_DUAL   = 2'b01,
    SPI_QUAD   = 2'b10
  } spi_mode_e;

  // Command generator FSM
  typedef enum logic [1:0] {
    IDLE      = 2'b00,  // Waiting for a flash read
    ADR_PHASE = 2'b01,  // Address word goes out
    CMD_WAIT  = 2'b10,  // Controller still draining the FIFO
    READ_DATA = 2'b11   // Beats returned by the response side
  } cmd_state_e;

  //------------------------------------------------------------
  // One read configuration group
  //------------------------------------------------------------
  typedef struct packed {
    spi_mode_e  imode;      // Initial mode
    spi_mode_e  fmode;      // Final mode
    spi_mode_e  switch;     // Where the mode changes
    logic [3:0] seq;        // Phase sequence
    logic [1:0] addr_cnt;   // Address bytes
    logic [3:0] dummy_cnt;  // Dummy cycles
    logic [7:0] cmd;        // Flash opcode
    logic [7:0] mode;       // Mode byte
  } rd_cfg_t;

endpackage

/* source/qspim_wb_pkg.sv */
// Bus-side constants for the Wishbone to quad-SPI read front end
// Widths, address map and burst length, referenced by scoped name

package qspim_wb_pkg;

  //------------------------------------------------------------
  // Bus widths
  //------------------------------------------------------------
  localparam int WB_WIDTH = 32;  // Data and address width
  localparam int WB_SEL_W = 4;   // Byte enables
  localparam int BL_W     = 10;  // Burst length in words

  //------------------------------------------------------------
  // Address map
  //------------------------------------------------------------
  // Bit 28 clear selects flash memory, set selects register space
  localparam int REG_SEL_BIT = 28;

  // Field compared against the chip-select address/mask pairs
  localparam int CS_MSB = 27;
  localparam int CS_LSB = 20;

  localparam int REG_ADDR_W = 4;  // Word address, taken from bits 5:2

endpackage
